// ==== common/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// PC value loaded at reset.
`define MIPS_RESET_PC 32'h0000_0000

// Data word width.
`define MIPS_XLEN 32

`endif

// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // One instruction word read as R, I or J format.
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_u;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BGEZ  = 6'b000001,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_BLEZ  = 6'b000110,
        OP_BGTZ  = 6'b000111,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL     = 6'b000000,
        FN_SRL     = 6'b000010,
        FN_SRA     = 6'b000011,
        FN_SLLV    = 6'b000100,
        FN_SRLV    = 6'b000110,
        FN_JR      = 6'b001000,
        FN_SYSCALL = 6'b001100,
        FN_ADD     = 6'b100000,
        FN_ADDU    = 6'b100001,
        FN_SUB     = 6'b100010,
        FN_SUBU    = 6'b100011,
        FN_AND     = 6'b100100,
        FN_OR      = 6'b100101,
        FN_XOR     = 6'b100110,
        FN_NOR     = 6'b100111,
        FN_SLT     = 6'b101010
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASS_A
    } alu_op_e;

endpackage

`default_nettype wire

// ==== common/ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

    logic               alu_src;
    logic               reg_dest;
    logic               link;
    logic               mem_to_reg;
    logic               branch_taken;
    logic               jump;
    logic               jump_register;
    logic               reg_write;
    logic               mem_write;
    logic               shift_by_shamt;
    logic               zero_extend;
    mips_pkg::alu_op_e  alu_op;

    modport decoder (
        output alu_src, reg_dest, link, mem_to_reg, branch_taken, jump,
        output jump_register, reg_write, mem_write, shift_by_shamt, zero_extend,
        output alu_op
    );

    modport datapath (
        input alu_src, reg_dest, link, mem_to_reg, branch_taken, jump,
        input jump_register, reg_write, mem_write, shift_by_shamt, zero_extend,
        input alu_op
    );

endinterface

`default_nettype wire

// ==== control/alu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_controller (
    input  mips_pkg::instr_u   instr,
    output mips_pkg::alu_op_e  alu_op
);

    always_comb begin
        alu_op = mips_pkg::ALU_ADD;
        case (instr.r.opcode)
            mips_pkg::OP_RTYPE: begin
                case (instr.r.funct)
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB, mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:                    alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:                     alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:                    alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:                    alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:                    alu_op = mips_pkg::ALU_SLT;
                    // Fixed and variable shifts share one ALU op.
                    mips_pkg::FN_SLL, mips_pkg::FN_SLLV: alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL, mips_pkg::FN_SRLV: alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:                    alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_JR:                     alu_op = mips_pkg::ALU_PASS_A;
                    default:                             alu_op = mips_pkg::ALU_ADD;
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU,
            mips_pkg::OP_LW, mips_pkg::OP_SW:    alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_ANDI:                   alu_op = mips_pkg::ALU_AND;
            mips_pkg::OP_ORI:                    alu_op = mips_pkg::ALU_OR;
            mips_pkg::OP_XORI:                   alu_op = mips_pkg::ALU_XOR;
            mips_pkg::OP_SLTI:                   alu_op = mips_pkg::ALU_SLT;
            mips_pkg::OP_LUI:                    alu_op = mips_pkg::ALU_LUI;
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE:  alu_op = mips_pkg::ALU_SUB;
            // Compare rs against zero through the flags.
            mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ,
            mips_pkg::OP_BGEZ:                   alu_op = mips_pkg::ALU_PASS_A;
            default:                             alu_op = mips_pkg::ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

// ==== control/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  mips_pkg::instr_u     instr,
    input  wire logic            zero,
    input  wire logic            negative,
    ctrl_if.decoder              ctrl,
    output logic                 halted
);

    logic is_syscall;
    logic is_branch;
    logic reg_write_raw;
    logic mem_write_raw;
    logic halt_q;

    alu_controller alu_controller_inst (
        .instr  (instr),
        .alu_op (ctrl.alu_op)
    );

    always_comb begin
        ctrl.alu_src        = 1'b0;
        ctrl.reg_dest       = 1'b0;
        ctrl.link           = 1'b0;
        ctrl.mem_to_reg     = 1'b0;
        ctrl.jump           = 1'b0;
        ctrl.jump_register  = 1'b0;
        ctrl.shift_by_shamt = 1'b0;
        ctrl.zero_extend    = 1'b0;
        reg_write_raw       = 1'b0;
        mem_write_raw       = 1'b0;
        is_syscall          = 1'b0;
        is_branch           = 1'b0;

        case (instr.r.opcode)
            mips_pkg::OP_RTYPE: begin
                case (instr.r.funct)
                    mips_pkg::FN_SYSCALL: is_syscall = 1'b1;
                    mips_pkg::FN_JR:      ctrl.jump_register = 1'b1;
                    mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
                        ctrl.reg_dest       = 1'b1;
                        ctrl.shift_by_shamt = 1'b1;
                        reg_write_raw       = 1'b1;
                    end
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
                    mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR,
                    mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT,
                    mips_pkg::FN_SLLV, mips_pkg::FN_SRLV: begin
                        ctrl.reg_dest = 1'b1;
                        reg_write_raw = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI: begin
                ctrl.alu_src  = 1'b1;
                reg_write_raw = 1'b1;
            end
            // Logic immediates and LUI take the raw 16 bits.
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                ctrl.alu_src     = 1'b1;
                ctrl.zero_extend = 1'b1;
                reg_write_raw    = 1'b1;
            end
            mips_pkg::OP_LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                reg_write_raw   = 1'b1;
            end
            mips_pkg::OP_SW: begin
                ctrl.alu_src  = 1'b1;
                mem_write_raw = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ,
            mips_pkg::OP_BGTZ, mips_pkg::OP_BGEZ: is_branch = 1'b1;
            mips_pkg::OP_J:   ctrl.jump = 1'b1;
            mips_pkg::OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                reg_write_raw = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Branch condition from the ALU flags of this cycle.
    always_comb begin
        ctrl.branch_taken = 1'b0;
        if (is_branch) begin
            case (instr.i.opcode)
                mips_pkg::OP_BEQ:  ctrl.branch_taken = zero;
                mips_pkg::OP_BNE:  ctrl.branch_taken = ~zero;
                mips_pkg::OP_BLEZ: ctrl.branch_taken = zero | negative;
                mips_pkg::OP_BGTZ: ctrl.branch_taken = ~zero & ~negative;
                mips_pkg::OP_BGEZ: ctrl.branch_taken = ~negative;
                default:           ctrl.branch_taken = 1'b0;
            endcase
        end
    end

    // Halt is sticky until reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (is_syscall) begin
            halt_q <= 1'b1;
        end
    end

    assign ctrl.reg_write = reg_write_raw & ~halt_q;
    assign ctrl.mem_write = mem_write_raw & ~halt_q;
    assign halted         = halt_q;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module reg_file (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [4:0]             rs_addr,
    input  wire logic [4:0]             rt_addr,
    input  wire logic [4:0]             rd_addr,
    input  wire logic [`MIPS_XLEN-1:0]  wdata,
    input  wire logic                   we,
    output logic      [`MIPS_XLEN-1:0]  rs_data,
    output logic      [`MIPS_XLEN-1:0]  rt_data
);

    logic [`MIPS_XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= wdata;
        end
    end

    // r0 is never written, so it reads as zero.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module alu (
    input  wire logic [`MIPS_XLEN-1:0]  a,
    input  wire logic [`MIPS_XLEN-1:0]  b,
    input  wire logic [4:0]             shamt,
    input  mips_pkg::alu_op_e           op,
    output logic      [`MIPS_XLEN-1:0]  result,
    output logic                        zero,
    output logic                        negative
);

    logic slt_bit;

    assign slt_bit = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD:    result = a + b;
            mips_pkg::ALU_SUB:    result = a - b;
            mips_pkg::ALU_AND:    result = a & b;
            mips_pkg::ALU_OR:     result = a | b;
            mips_pkg::ALU_XOR:    result = a ^ b;
            mips_pkg::ALU_NOR:    result = ~(a | b);
            mips_pkg::ALU_SLT:    result = {{(`MIPS_XLEN-1){1'b0}}, slt_bit};
            // Shifts act on the rt operand.
            mips_pkg::ALU_SLL:    result = b << shamt;
            mips_pkg::ALU_SRL:    result = b >> shamt;
            mips_pkg::ALU_SRA:    result = $signed(b) >>> shamt;
            mips_pkg::ALU_LUI:    result = {b[15:0], {(`MIPS_XLEN-16){1'b0}}};
            mips_pkg::ALU_PASS_A: result = a;
            default:              result = '0;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[`MIPS_XLEN-1];

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    output logic      [`MIPS_XLEN-1:0]  imem_addr,
    input  wire logic [`MIPS_XLEN-1:0]  imem_data,
    output logic      [`MIPS_XLEN-1:0]  dmem_addr,
    output logic      [`MIPS_XLEN-1:0]  dmem_wdata,
    output logic                        dmem_we,
    input  wire logic [`MIPS_XLEN-1:0]  dmem_rdata,
    output logic                        halted
);

    mips_pkg::instr_u       instr;
    logic [`MIPS_XLEN-1:0]  pc;
    logic [`MIPS_XLEN-1:0]  pc_plus4;
    logic [`MIPS_XLEN-1:0]  branch_target;
    logic [`MIPS_XLEN-1:0]  jump_target;
    logic [`MIPS_XLEN-1:0]  next_pc;
    logic [`MIPS_XLEN-1:0]  imm_ext;
    logic [`MIPS_XLEN-1:0]  rs_data;
    logic [`MIPS_XLEN-1:0]  rt_data;
    logic [`MIPS_XLEN-1:0]  alu_b;
    logic [`MIPS_XLEN-1:0]  alu_result;
    logic [`MIPS_XLEN-1:0]  wb_data;
    logic [4:0]             wb_addr;
    logic [4:0]             shift_amt;
    logic                   alu_zero;
    logic                   alu_negative;

    ctrl_if ctrl_bus ();

    assign instr     = imem_data;
    assign imem_addr = pc;

    control_unit control_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .zero     (alu_zero),
        .negative (alu_negative),
        .ctrl     (ctrl_bus.decoder),
        .halted   (halted)
    );

    assign imm_ext = ctrl_bus.zero_extend
                   ? {{(`MIPS_XLEN-16){1'b0}}, instr.i.imm16}
                   : {{(`MIPS_XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};

    assign pc_plus4      = pc + `MIPS_XLEN'd4;
    assign branch_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
    assign jump_target   = {pc_plus4[`MIPS_XLEN-1:28], instr.j.target26, 2'b00};

    always_comb begin
        if (ctrl_bus.jump_register) begin
            next_pc = rs_data;
        end else if (ctrl_bus.jump) begin
            next_pc = jump_target;
        end else if (ctrl_bus.branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // Fetch stops once the core has halted.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else if (!halted) begin
            pc <= next_pc;
        end
    end

    assign wb_addr = ctrl_bus.link     ? 5'd31
                   : ctrl_bus.reg_dest ? instr.r.rd
                   :                     instr.r.rt;

    assign wb_data = ctrl_bus.link       ? pc_plus4
                   : ctrl_bus.mem_to_reg ? dmem_rdata
                   :                       alu_result;

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (instr.r.rs),
        .rt_addr (instr.r.rt),
        .rd_addr (wb_addr),
        .wdata   (wb_data),
        .we      (ctrl_bus.reg_write),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign alu_b     = ctrl_bus.alu_src ? imm_ext : rt_data;
    assign shift_amt = ctrl_bus.shift_by_shamt ? instr.r.shamt : rs_data[4:0];

    alu alu_inst (
        .a        (rs_data),
        .b        (alu_b),
        .shamt    (shift_amt),
        .op       (ctrl_bus.alu_op),
        .result   (alu_result),
        .zero     (alu_zero),
        .negative (alu_negative)
    );

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rt_data;
    assign dmem_we    = ctrl_bus.mem_write;

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core_tb;

    localparam int NUM_ENTRIES = 8;
    localparam int MAX_WORDS   = 16;
    localparam int MAX_STORES  = 6;

    logic        clk;
    logic        gen_rst_n;
    logic        tb_rst_n;
    logic        core_rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        halted;
    logic [31:0] fetch_off;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];

    // Program table with code, initial data and expected stores per entry.
    logic [31:0] prog     [NUM_ENTRIES][MAX_WORDS];
    logic [31:0] init_data[NUM_ENTRIES][4];
    logic [31:0] exp_addr [NUM_ENTRIES][MAX_STORES];
    logic [31:0] exp_data [NUM_ENTRIES][MAX_STORES];
    int          exp_cnt  [NUM_ENTRIES];
    int          cur;
    int          wp;

    clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (gen_rst_n)
    );

    assign core_rst_n = gen_rst_n & tb_rst_n;

    mips_core mips_core_inst (
        .clk        (clk),
        .rst_n      (core_rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    // Both memories read combinationally.
    assign fetch_off  = imem_addr - `MIPS_RESET_PC;
    assign imem_data  = imem[fetch_off[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (core_rst_n && dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
            st_addr.push_back(dmem_addr);
            st_data.push_back(dmem_wdata);
        end
    end

    function automatic logic [31:0] asm_r(mips_pkg::funct_e fn, int rs, int rt, int rd,
                                          int sh);
        mips_pkg::instr_u w;
        w.r.opcode = mips_pkg::OP_RTYPE;
        w.r.rs     = rs[4:0];
        w.r.rt     = rt[4:0];
        w.r.rd     = rd[4:0];
        w.r.shamt  = sh[4:0];
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic logic [31:0] asm_i(mips_pkg::opcode_e op, int rs, int rt, int imm);
        mips_pkg::instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs[4:0];
        w.i.rt     = rt[4:0];
        w.i.imm16  = imm[15:0];
        return w;
    endfunction

    function automatic logic [31:0] asm_j(mips_pkg::opcode_e op, int word_index);
        mips_pkg::instr_u w;
        logic [31:0]      target;
        target        = (`MIPS_RESET_PC >> 2) + word_index;
        w.j.opcode    = op;
        w.j.target26  = target[25:0];
        return w;
    endfunction

    task automatic start_entry(int e);
        cur          = e;
        wp           = 0;
        exp_cnt[e]   = 0;
        for (int k = 0; k < MAX_WORDS; k++) begin
            prog[e][k] = asm_r(mips_pkg::FN_SYSCALL, 0, 0, 0, 0);
        end
        for (int k = 0; k < 4; k++) begin
            init_data[e][k] = 32'h0;
        end
    endtask

    task automatic emit(logic [31:0] w);
        prog[cur][wp] = w;
        wp++;
    endtask

    task automatic expect_store(logic [31:0] a, logic [31:0] d);
        exp_addr[cur][exp_cnt[cur]] = a;
        exp_data[cur][exp_cnt[cur]] = d;
        exp_cnt[cur]++;
    endtask

    task automatic compare(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic load_memories(int e);
        for (int k = 0; k < 64; k++) begin
            imem[k] <= (k < MAX_WORDS) ? prog[e][k] : asm_r(mips_pkg::FN_SYSCALL, 0, 0, 0, 0);
            dmem[k] <= 32'hd00d_0000 | (k << 2);
        end
        for (int k = 0; k < 4; k++) begin
            dmem[k] <= init_data[e][k];
        end
    endtask

    task automatic build_table();
        // R-type group one with r1 = 7 and r2 = -3.
        start_entry(0);
        init_data[0][0] = 32'h0000_0007;
        init_data[0][1] = 32'hffff_fffd;
        emit(asm_i(mips_pkg::OP_LW, 0, 1, 0));
        emit(asm_i(mips_pkg::OP_LW, 0, 2, 4));
        emit(asm_r(mips_pkg::FN_ADD, 1, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h40));
        emit(asm_r(mips_pkg::FN_SUB, 1, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h44));
        emit(asm_r(mips_pkg::FN_AND, 1, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h48));
        emit(asm_r(mips_pkg::FN_OR, 1, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h4c));
        emit(asm_r(mips_pkg::FN_SLT, 2, 1, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h50));
        expect_store(32'h40, 32'h0000_0004);
        expect_store(32'h44, 32'h0000_000a);
        expect_store(32'h48, 32'h0000_0005);
        expect_store(32'h4c, 32'hffff_ffff);
        expect_store(32'h50, 32'h0000_0001);

        // R-type group two.
        start_entry(1);
        init_data[1][0] = 32'h0000_0007;
        init_data[1][1] = 32'hffff_fffd;
        emit(asm_i(mips_pkg::OP_LW, 0, 1, 0));
        emit(asm_i(mips_pkg::OP_LW, 0, 2, 4));
        emit(asm_r(mips_pkg::FN_ADDU, 2, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h40));
        emit(asm_r(mips_pkg::FN_SUBU, 2, 1, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h44));
        emit(asm_r(mips_pkg::FN_XOR, 1, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h48));
        emit(asm_r(mips_pkg::FN_NOR, 1, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h4c));
        emit(asm_r(mips_pkg::FN_SLT, 1, 2, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h50));
        expect_store(32'h40, 32'hffff_fffa);
        expect_store(32'h44, 32'hffff_fff6);
        expect_store(32'h48, 32'hffff_fffa);
        expect_store(32'h4c, 32'h0000_0000);
        expect_store(32'h50, 32'h0000_0000);

        // Fixed and variable shifts.
        start_entry(2);
        init_data[2][0] = 32'h8000_0010;
        emit(asm_i(mips_pkg::OP_LW, 0, 1, 0));
        emit(asm_i(mips_pkg::OP_ADDI, 0, 2, 8));
        emit(asm_r(mips_pkg::FN_SLL, 0, 1, 3, 4));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h40));
        emit(asm_r(mips_pkg::FN_SRL, 0, 1, 3, 4));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h44));
        emit(asm_r(mips_pkg::FN_SRA, 0, 1, 3, 4));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h48));
        emit(asm_r(mips_pkg::FN_SLLV, 2, 1, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h4c));
        emit(asm_r(mips_pkg::FN_SRLV, 2, 1, 3, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h50));
        expect_store(32'h40, 32'h0000_0100);
        expect_store(32'h44, 32'h0800_0001);
        expect_store(32'h48, 32'hf800_0001);
        expect_store(32'h4c, 32'h0000_1000);
        expect_store(32'h50, 32'h0080_0000);

        // Immediates with sign and zero extension.
        start_entry(3);
        emit(asm_i(mips_pkg::OP_ADDI, 0, 1, -16));
        emit(asm_i(mips_pkg::OP_SW, 0, 1, 'h40));
        emit(asm_i(mips_pkg::OP_SLTI, 1, 2, -1));
        emit(asm_i(mips_pkg::OP_SW, 0, 2, 'h44));
        emit(asm_i(mips_pkg::OP_ANDI, 1, 3, 'hff0f));
        emit(asm_i(mips_pkg::OP_SW, 0, 3, 'h48));
        emit(asm_i(mips_pkg::OP_ORI, 0, 4, 'h8001));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h4c));
        emit(asm_i(mips_pkg::OP_XORI, 1, 5, 'hffff));
        emit(asm_i(mips_pkg::OP_SW, 0, 5, 'h50));
        emit(asm_i(mips_pkg::OP_ADDIU, 1, 6, 'h8000));
        emit(asm_i(mips_pkg::OP_SW, 0, 6, 'h54));
        expect_store(32'h40, 32'hffff_fff0);
        expect_store(32'h44, 32'h0000_0001);
        expect_store(32'h48, 32'h0000_ff00);
        expect_store(32'h4c, 32'h0000_8001);
        expect_store(32'h50, 32'hffff_000f);
        expect_store(32'h54, 32'hffff_7ff0);

        // LUI, r0 stays zero, load round trip.
        start_entry(4);
        init_data[4][2] = 32'h1111_1111;
        emit(asm_i(mips_pkg::OP_LUI, 0, 7, 'h1234));
        emit(asm_i(mips_pkg::OP_SW, 0, 7, 'h40));
        emit(asm_i(mips_pkg::OP_ADDI, 0, 0, 5));
        emit(asm_i(mips_pkg::OP_SW, 0, 0, 'h44));
        emit(asm_i(mips_pkg::OP_LW, 0, 1, 8));
        emit(asm_r(mips_pkg::FN_ADDU, 1, 7, 2, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 2, 'h48));
        expect_store(32'h40, 32'h1234_0000);
        expect_store(32'h44, 32'h0000_0000);
        expect_store(32'h48, 32'h2345_1111);

        // Each taken BEQ, BNE or BLEZ jumps over one SW.
        start_entry(5);
        emit(asm_i(mips_pkg::OP_ADDI, 0, 1, -5));
        emit(asm_i(mips_pkg::OP_ADDI, 0, 2, 5));
        emit(asm_i(mips_pkg::OP_ADDI, 0, 4, 'h77));
        emit(asm_i(mips_pkg::OP_BEQ, 2, 2, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h40));
        emit(asm_i(mips_pkg::OP_BEQ, 1, 2, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h44));
        emit(asm_i(mips_pkg::OP_BNE, 1, 2, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h48));
        emit(asm_i(mips_pkg::OP_BNE, 2, 2, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h4c));
        emit(asm_i(mips_pkg::OP_BLEZ, 0, 0, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h50));
        expect_store(32'h44, 32'h0000_0077);
        expect_store(32'h4c, 32'h0000_0077);

        // BLEZ, BGTZ and BGEZ with negative, positive and zero operands.
        start_entry(6);
        emit(asm_i(mips_pkg::OP_ADDI, 0, 1, -5));
        emit(asm_i(mips_pkg::OP_ADDI, 0, 2, 5));
        emit(asm_i(mips_pkg::OP_ADDI, 0, 4, 'h66));
        emit(asm_i(mips_pkg::OP_BLEZ, 1, 0, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h40));
        emit(asm_i(mips_pkg::OP_BLEZ, 2, 0, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h44));
        emit(asm_i(mips_pkg::OP_BGTZ, 2, 0, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h48));
        emit(asm_i(mips_pkg::OP_BGTZ, 0, 0, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h4c));
        emit(asm_i(mips_pkg::OP_BGEZ, 0, 1, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h50));
        emit(asm_i(mips_pkg::OP_BGEZ, 1, 1, 1));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h54));
        expect_store(32'h44, 32'h0000_0066);
        expect_store(32'h4c, 32'h0000_0066);
        expect_store(32'h54, 32'h0000_0066);

        // J skips, JAL links to word 4, JR returns there.
        start_entry(7);
        emit(asm_i(mips_pkg::OP_ADDI, 0, 4, 'h55));
        emit(asm_j(mips_pkg::OP_J, 3));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h40));
        emit(asm_j(mips_pkg::OP_JAL, 6));
        emit(asm_i(mips_pkg::OP_SW, 0, 31, 'h44));
        emit(asm_r(mips_pkg::FN_SYSCALL, 0, 0, 0, 0));
        emit(asm_i(mips_pkg::OP_SW, 0, 4, 'h48));
        emit(asm_r(mips_pkg::FN_JR, 31, 0, 0, 0));
        expect_store(32'h48, 32'h0000_0055);
        expect_store(32'h44, `MIPS_RESET_PC + 32'h10);
    endtask

    task automatic run_entry(int e);
        logic [31:0] held_pc;
        int          seen;
        @(posedge clk);
        tb_rst_n <= 1'b0;
        load_memories(e);
        st_addr.delete();
        st_data.delete();
        repeat (3) @(posedge clk);
        tb_rst_n <= 1'b1;

        @(negedge clk);
        while (!halted) begin
            @(negedge clk);
        end
        held_pc = imem_addr;
        seen    = st_addr.size();
        repeat (5) begin
            @(negedge clk);
            compare("halted", {31'b0, halted}, 32'h1);
            compare("imem_addr", imem_addr, held_pc);
        end
        if (st_addr.size() != seen) begin
            $display("entry %0d: a store happened after the core halted", e);
            $display("RESULT: FAIL");
            $fatal(1, "store after halt");
        end
        if (seen != exp_cnt[e]) begin
            $display("entry %0d: saw %0d stores but expected %0d", e, seen, exp_cnt[e]);
            $display("RESULT: FAIL");
            $fatal(1, "store count differs");
        end
        for (int k = 0; k < seen; k++) begin
            compare("dmem_addr", st_addr[k], exp_addr[e][k]);
            compare("dmem_wdata", st_data[k], exp_data[e][k]);
        end
    endtask

    initial begin
        #(NUM_ENTRIES * 64 * 10);
        $display("RESULT: FAIL");
        $fatal(1, "timeout: the core did not halt in time");
    end

    initial begin
        tb_rst_n <= 1'b0;
        build_table();
        load_memories(0);
        @(posedge gen_rst_n);
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_core.f ====
+incdir+common
common/mips_pkg.sv
common/ctrl_if.sv
control/alu_controller.sv
control/control_unit.sv
source/reg_file.sv
source/alu.sv
source/mips_core.sv
bench/clock_gen.sv
bench/mips_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the exit status is the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f mips_core.f \
    --top-module mips_core_tb \
    -o mips_core_sim

./obj_dir/mips_core_sim
